//--- source/bincap_defines.svh
`ifndef BINCAP_DEFINES_SVH
`define BINCAP_DEFINES_SVH

// frame geometry, any power of two.
`define BINCAP_FRAME_PIXELS 64

// threshold after reset, only full white counts as foreground.
`define BINCAP_THRESH_RESET 8'd255

// register byte offsets on the wishbone port.
`define BINCAP_REG_CTRL     8'h00
`define BINCAP_REG_THRESH   8'h04
`define BINCAP_REG_STATUS   8'h08
`define BINCAP_REG_COUNT    8'h0C
`define BINCAP_REG_PIX_ADDR 8'h10
`define BINCAP_REG_PIX_DATA 8'h14

`endif

//--- source/bincap_pkg.sv
`include "bincap_defines.svh"

package bincap_pkg;

    typedef logic [7:0] pixel_t;  // grey level.

    // one address per stored bit.
    typedef logic [$clog2(`BINCAP_FRAME_PIXELS)-1:0] pix_addr_t;

    // one extra bit so a fully white frame still fits.
    typedef logic [$clog2(`BINCAP_FRAME_PIXELS):0] pix_count_t;

    typedef logic [7:0]  wb_addr_t;  // byte address.
    typedef logic [31:0] wb_data_t;

    typedef enum logic [1:0] {
        IDLE,
        CAPTURING,
        COMPLETE
    } capture_state_t;

endpackage

//--- source/wb_reg_decode.sv
`timescale 1ns/1ps
`include "bincap_defines.svh"

module wb_reg_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  bincap_pkg::wb_addr_t   wb_adr,
    input  bincap_pkg::wb_data_t   wb_dat_w,
    output bincap_pkg::wb_data_t   wb_dat_r,
    output logic                   wb_ack,
    input  logic                   capturing,
    input  logic                   frame_valid,
    input  logic                   pix_bit,
    input  bincap_pkg::pix_count_t fg_count,
    output logic                   start,
    output bincap_pkg::pixel_t     threshold,
    output bincap_pkg::pix_addr_t  pix_addr
);

    localparam logic [1:0] WAIT_IDLE = 2'd0;
    localparam logic [1:0] WAIT_MEM  = 2'd1;  // extra cycle for the memory read.
    localparam logic [1:0] WAIT_DONE = 2'd2;  // acked, waiting for stb to drop.

    logic [1:0]           wait_cnt;
    logic                 req;
    logic                 slow_rd;
    logic                 ack_set;
    logic                 wr_fire;
    bincap_pkg::wb_data_t rd_mux;

    assign req     = wb_cyc && wb_stb;
    assign slow_rd = !wb_we && (wb_adr == `BINCAP_REG_PIX_DATA);
    assign ack_set = req && ((wait_cnt == WAIT_IDLE && !slow_rd) || wait_cnt == WAIT_MEM);
    assign wr_fire = req && wb_ack && wb_we;  // writes land on the ack edge.

    always_comb begin
        case (wb_adr)
            `BINCAP_REG_THRESH:   rd_mux = bincap_pkg::wb_data_t'(threshold);
            `BINCAP_REG_STATUS:   rd_mux = {30'd0, frame_valid, capturing};
            `BINCAP_REG_COUNT:    rd_mux = bincap_pkg::wb_data_t'(fg_count);
            `BINCAP_REG_PIX_ADDR: rd_mux = bincap_pkg::wb_data_t'(pix_addr);
            `BINCAP_REG_PIX_DATA: rd_mux = {31'd0, pix_bit};
            default:              rd_mux = '0;  // ctrl and unmapped.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= WAIT_IDLE;
            wb_ack   <= 1'b0;
        end else begin
            wb_ack <= ack_set;
            if (!req) begin
                wait_cnt <= WAIT_IDLE;
            end else if (wait_cnt == WAIT_IDLE) begin
                wait_cnt <= slow_rd ? WAIT_MEM : WAIT_DONE;
            end else begin
                wait_cnt <= WAIT_DONE;
            end
        end
    end

    // sampled together with the ack.
    always_ff @(posedge clk) begin
        if (ack_set)
            wb_dat_r <= rd_mux;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start     <= 1'b0;
            threshold <= `BINCAP_THRESH_RESET;
            pix_addr  <= '0;
        end else begin
            start <= wr_fire && (wb_adr == `BINCAP_REG_CTRL) && wb_dat_w[0];  // one cycle.
            if (wr_fire && wb_adr == `BINCAP_REG_THRESH)
                threshold <= bincap_pkg::pixel_t'(wb_dat_w);
            if (wr_fire && wb_adr == `BINCAP_REG_PIX_ADDR)
                pix_addr <= bincap_pkg::pix_addr_t'(wb_dat_w);
        end
    end

endmodule

//--- source/binary_frame_capture.sv
`timescale 1ns/1ps
`include "bincap_defines.svh"

module binary_frame_capture (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_valid,
    output logic                  pix_ready,
    input  bincap_pkg::pixel_t    pix_data,
    input  bincap_pkg::pixel_t    threshold,
    input  logic                  start,
    input  bincap_pkg::pix_addr_t pix_addr,
    output logic                  pix_bit,
    output logic                  capturing,
    output logic                  frame_valid,
    output logic                  capture_done,
    output logic                  frame_start,
    output logic                  pix_fire,
    output logic                  fg_pixel
);

    localparam int FRAME_PIXELS = `BINCAP_FRAME_PIXELS;

    bincap_pkg::capture_state_t state;
    bincap_pkg::pix_addr_t      wr_addr;
    logic                       last_pixel;

    (* ramstyle = "M9K" *) logic frame_mem [0:FRAME_PIXELS-1];

    assign pix_ready   = (state == bincap_pkg::CAPTURING);
    assign pix_fire    = pix_valid && pix_ready;
    assign fg_pixel    = (pix_data >= threshold);  // at or above counts as foreground.
    assign frame_start = start && (state == bincap_pkg::IDLE);  // starts while busy are dropped.
    assign last_pixel  = (wr_addr == bincap_pkg::pix_addr_t'(FRAME_PIXELS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= bincap_pkg::IDLE;
            wr_addr      <= '0;
            capturing    <= 1'b0;
            frame_valid  <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            capture_done <= 1'b0;
            case (state)
                bincap_pkg::IDLE: begin
                    if (frame_start) begin
                        state       <= bincap_pkg::CAPTURING;
                        wr_addr     <= '0;
                        capturing   <= 1'b1;
                        frame_valid <= 1'b0;  // old frame is being overwritten.
                    end
                end
                bincap_pkg::CAPTURING: begin
                    if (pix_fire) begin
                        wr_addr <= wr_addr + 1'b1;  // wraps to 0 after the last pixel.
                        if (last_pixel)
                            state <= bincap_pkg::COMPLETE;
                    end
                end
                bincap_pkg::COMPLETE: begin
                    state        <= bincap_pkg::IDLE;
                    capturing    <= 1'b0;
                    frame_valid  <= 1'b1;
                    capture_done <= 1'b1;
                end
                default: state <= bincap_pkg::IDLE;
            endcase
        end
    end

    // write port, one bit per accepted pixel.
    always_ff @(posedge clk) begin
        if (pix_fire)
            frame_mem[wr_addr] <= fg_pixel;
    end

    // registered read, so the memory maps onto a block ram.
    always_ff @(posedge clk) begin
        if (frame_valid)
            pix_bit <= frame_mem[pix_addr];
    end

endmodule

//--- source/foreground_counter.sv
`timescale 1ns/1ps

module foreground_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_start,
    input  logic                   pix_fire,
    input  logic                   fg_pixel,
    output bincap_pkg::pix_count_t fg_count
);

    logic count_en;

    // only accepted pixels that passed the threshold.
    assign count_en = pix_fire && fg_pixel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fg_count <= '0;
        end else if (frame_start) begin
            fg_count <= '0;  // cleared as the capture begins.
        end else if (count_en) begin
            fg_count <= fg_count + 1'b1;
        end
    end

endmodule

//--- source/bincap_top.sv
`timescale 1ns/1ps

module bincap_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  bincap_pkg::wb_addr_t wb_adr,
    input  bincap_pkg::wb_data_t wb_dat_w,
    output bincap_pkg::wb_data_t wb_dat_r,
    output logic                 wb_ack,
    input  logic                 pix_valid,
    output logic                 pix_ready,
    input  bincap_pkg::pixel_t   pix_data,
    output logic                 capture_done
);

    logic                   start;
    bincap_pkg::pixel_t     threshold;
    bincap_pkg::pix_addr_t  pix_addr;
    logic                   pix_bit;
    logic                   capturing;
    logic                   frame_valid;
    logic                   frame_start;
    logic                   pix_fire;
    logic                   fg_pixel;
    bincap_pkg::pix_count_t fg_count;

    // host side.
    wb_reg_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .capturing   (capturing),
        .frame_valid (frame_valid),
        .pix_bit     (pix_bit),
        .fg_count    (fg_count),
        .start       (start),
        .threshold   (threshold),
        .pix_addr    (pix_addr)
    );

    binary_frame_capture u_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .pix_data     (pix_data),
        .threshold    (threshold),
        .start        (start),
        .pix_addr     (pix_addr),
        .pix_bit      (pix_bit),
        .capturing    (capturing),
        .frame_valid  (frame_valid),
        .capture_done (capture_done),
        .frame_start  (frame_start),
        .pix_fire     (pix_fire),
        .fg_pixel     (fg_pixel)
    );

    foreground_counter u_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .pix_fire    (pix_fire),
        .fg_pixel    (fg_pixel),
        .fg_count    (fg_count)
    );

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- dv/bincap_props.sv
`timescale 1ns/1ps

module bincap_props (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic capture_done,
    input logic pix_ready,
    input logic frame_valid
);

    // slave only answers an open request.
    ack_in_request: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack raised without wb_cyc and wb_stb");

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        capture_done |=> !capture_done)
        else $error("capture_done held longer than one cycle");

    // a stored frame is never overwritten while marked valid.
    ready_not_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !(pix_ready && frame_valid))
        else $error("pix_ready high while frame_valid is high");

endmodule

bind bincap_top bincap_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .capture_done (capture_done),
    .pix_ready    (pix_ready),
    .frame_valid  (frame_valid)
);

//--- dv/bincap_tb.sv
`timescale 1ns/1ps
`include "bincap_defines.svh"

module bincap_tb;

    localparam int FRAME_PIXELS = `BINCAP_FRAME_PIXELS;
    localparam int NUM_FRAMES   = 3;
    // two accesses per pixel readback plus setup and status traffic.
    localparam int REG_OPS    = NUM_FRAMES * (2 * FRAME_PIXELS + 8) + 16;
    localparam int MAX_CYCLES = 4 * NUM_FRAMES * FRAME_PIXELS + 4 * REG_OPS + 200;

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    bincap_pkg::wb_addr_t wb_adr;
    bincap_pkg::wb_data_t wb_dat_w;
    bincap_pkg::wb_data_t wb_dat_r;
    logic                 wb_ack;
    logic                 pix_valid;
    logic                 pix_ready;
    bincap_pkg::pixel_t   pix_data;
    logic                 capture_done;

    logic                 exp_bits [0:FRAME_PIXELS-1];  // reference frame.
    int                   exp_addr;
    int                   exp_count;
    int                   done_count;
    int                   cycles;
    int                   errors;
    bincap_pkg::pixel_t   cur_thresh;
    bincap_pkg::wb_data_t rd_val;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bincap_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .pix_data     (pix_data),
        .capture_done (capture_done)
    );

    // at or above threshold is foreground.
    function automatic logic binarize(input bincap_pkg::pixel_t p, input bincap_pkg::pixel_t thr);
        return (p >= thr);
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // one classic cycle held until ack and dropped the cycle after.
    task automatic wb_access(input logic we, input bincap_pkg::wb_addr_t adr,
                             input bincap_pkg::wb_data_t wdat, output bincap_pkg::wb_data_t rdat);
        int lat;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        lat      = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!wb_ack);
        rdat = wb_dat_r;
        check_eq(lat, (!we && adr == `BINCAP_REG_PIX_DATA) ? 2 : 1, "wishbone ack latency");
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check_eq(32'(wb_ack), 0, "wb_ack longer than one cycle");
    endtask

    task automatic wb_write(input bincap_pkg::wb_addr_t adr, input bincap_pkg::wb_data_t data);
        bincap_pkg::wb_data_t unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input bincap_pkg::wb_addr_t adr, output bincap_pkg::wb_data_t data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic offer_pixel(input bincap_pkg::pixel_t p);
        logic ready_seen;
        pix_valid = 1'b1;
        pix_data  = p;
        do begin
            @(negedge clk);
            ready_seen = pix_ready;  // taken on the coming edge.
            @(posedge clk);
            #1;
        end while (!ready_seen);
        pix_valid = 1'b0;
    endtask

    // a quarter of the pixels are full white.
    task automatic drive_frame();
        bincap_pkg::pixel_t p;
        int gap;
        int i;
        for (i = 0; i < FRAME_PIXELS; i++) begin
            gap = $urandom_range(3, 0);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            if ($urandom_range(3, 0) == 0)
                p = 8'd255;
            else
                p = bincap_pkg::pixel_t'($urandom_range(254, 0));
            offer_pixel(p);
        end
    endtask

    task automatic start_capture();
        exp_addr  = 0;
        exp_count = 0;
        wb_write(`BINCAP_REG_CTRL, 32'd1);
    endtask

    task automatic wait_done(input int n);
        wait (done_count >= n);
        @(posedge clk);
        #1;
    endtask

    task automatic check_frame(input string tag, input int frame_no);
        bincap_pkg::wb_data_t v;
        int a;
        for (a = 0; a < FRAME_PIXELS; a++) begin
            wb_write(`BINCAP_REG_PIX_ADDR, bincap_pkg::wb_data_t'(a));
            wb_read(`BINCAP_REG_PIX_DATA, v);
            check_eq(v, 32'(exp_bits[a]), $sformatf("%s pixel %0d", tag, a));
        end
        wb_read(`BINCAP_REG_COUNT, v);
        check_eq(v, exp_count, {tag, " foreground count"});
        wb_read(`BINCAP_REG_STATUS, v);
        check_eq(v, 32'h2, {tag, " status after capture"});
        check_eq(done_count, frame_no, {tag, " capture_done pulses"});
    endtask

    // reference model fed by every accepted pixel.
    always @(negedge clk) begin
        if (rst_n && pix_valid && pix_ready) begin
            check_eq(32'(exp_addr < FRAME_PIXELS), 1, "pixel accepted past the frame end");
            exp_bits[exp_addr] = binarize(pix_data, cur_thresh);
            if (binarize(pix_data, cur_thresh))
                exp_count++;
            exp_addr++;
        end
        if (rst_n && capture_done) begin
            check_eq(exp_addr, FRAME_PIXELS, "capture_done before the last pixel");
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, an ack or capture_done never came", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation hung");
        end
    end

    initial begin
        void'($urandom(32'hbdf94041));
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        pix_valid  = 1'b0;
        pix_data   = '0;
        exp_addr   = 0;
        exp_count  = 0;
        done_count = 0;
        cycles     = 0;
        errors     = 0;
        cur_thresh = `BINCAP_THRESH_RESET;
        foreach (exp_bits[i])
            exp_bits[i] = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;

        // reset values and unmapped space.
        check_eq(32'(pix_ready), 0, "pix_ready after reset");
        wb_write(8'h1C, 32'hFFFF_FF01);  // aliasing would show in the reads below.
        wb_read(8'h1C, rd_val);
        check_eq(rd_val, 0, "unmapped address");
        wb_read(`BINCAP_REG_STATUS, rd_val);
        check_eq(rd_val, 0, "status after reset");
        wb_read(`BINCAP_REG_THRESH, rd_val);
        check_eq(rd_val, 255, "threshold after reset");
        wb_read(`BINCAP_REG_COUNT, rd_val);
        check_eq(rd_val, 0, "count after reset");
        wb_read(`BINCAP_REG_CTRL, rd_val);
        check_eq(rd_val, 0, "ctrl reads zero");
        wb_read(`BINCAP_REG_PIX_ADDR, rd_val);
        check_eq(rd_val, 0, "pix_addr after reset");
        wb_write(`BINCAP_REG_PIX_ADDR, 32'd42);
        wb_read(`BINCAP_REG_PIX_ADDR, rd_val);
        check_eq(rd_val, 42, "pix_addr readback");

        start_capture();
        drive_frame();
        wait_done(1);
        check_frame("frame 1", 1);

        // idle source must not be taken.
        pix_valid = 1'b1;
        pix_data  = 8'd255;
        repeat (8) begin
            @(negedge clk);
            check_eq(32'(pix_ready), 0, "pix_ready while idle");
        end
        @(posedge clk);
        #1;
        pix_valid = 1'b0;

        wb_write(`BINCAP_REG_THRESH, 32'd128);
        cur_thresh = 8'd128;
        wb_read(`BINCAP_REG_THRESH, rd_val);
        check_eq(rd_val, 128, "threshold readback");
        start_capture();
        wb_read(`BINCAP_REG_STATUS, rd_val);
        check_eq(rd_val, 32'h1, "status while capturing");
        wb_read(`BINCAP_REG_COUNT, rd_val);
        check_eq(rd_val, 0, "count cleared at start");
        drive_frame();
        wait_done(2);
        check_frame("frame 2", 2);

        // second start in the middle of a frame.
        start_capture();
        fork
            drive_frame();
            begin
                wait (exp_addr >= 20);
                wb_write(`BINCAP_REG_CTRL, 32'd1);
            end
        join
        wait_done(3);
        check_frame("frame 3", NUM_FRAMES);

        if (errors == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- sim.f
+incdir+source
source/bincap_pkg.sv
source/wb_reg_decode.sv
source/binary_frame_capture.sv
source/foreground_counter.sv
source/bincap_top.sv
dv/clk_gen.sv
dv/bincap_props.sv
dv/bincap_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP       := bincap_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: simulate clean

# a $fatal in the testbench gives a non-zero exit status, so make fails too
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
